// ==== bench/tb_table.svh ====
// ====================
// test step type for the testbench
// table of steps with beats, gap, branch mode
// and whether o_ready must drop
// ====================

`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

typedef struct packed {
    int   beats;
    int   gap;
    logic rand_branch;
    logic expect_stall;
} step_t;

localparam int STEP_COUNT = 7;

// gap 0 holds i_valid high on every cycle
localparam step_t STEP_TABLE [STEP_COUNT] = '{
    '{beats: 1,  gap: 0, rand_branch: 1'b0, expect_stall: 1'b0},
    '{beats: 4,  gap: 3, rand_branch: 1'b1, expect_stall: 1'b0},
    '{beats: 3,  gap: 0, rand_branch: 1'b0, expect_stall: 1'b0},
    '{beats: 40, gap: 0, rand_branch: 1'b1, expect_stall: 1'b1},
    '{beats: 6,  gap: 9, rand_branch: 1'b1, expect_stall: 1'b0},
    '{beats: 24, gap: 0, rand_branch: 1'b0, expect_stall: 1'b1},
    '{beats: 8,  gap: 1, rand_branch: 1'b1, expect_stall: 1'b0}
};

`endif

// ==== bench/mimo_fifo_8_tb.sv ====
// ====================
// testbench for mimo_fifo_8
// clock, reset, table driven stimulus
// lane queue reference model and checks
// watchdog
// ====================

`timescale 1ns/1ps
`default_nettype none

module mimo_fifo_8_tb import mimo_pkg::*; ();

    `include "tb_table.svh"

    localparam int SEQ_WIDTH = DATA_WIDTH - BRANCH_WIDTH;

    logic          i_clock;
    logic          i_reset;
    lane_entries_t i_entries;
    logic          i_valid;
    logic          o_ready;
    data_t         o_data;
    lane_mask_t    o_valid;

    // reference model state
    lane_entry_t          model_q [NUM_LANES][$];
    lane_t                model_ptr;
    lane_mask_t           exp_valid;
    data_t                exp_data;
    logic                 exp_ready;
    logic [SEQ_WIDTH-1:0] next_seq [NUM_LANES];

    logic [15:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          delivered;

    mimo_fifo_8 mimo_fifo_8_i (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_entries (i_entries),
        .i_valid   (i_valid),
        .o_ready   (o_ready),
        .o_data    (o_data),
        .o_valid   (o_valid)
    );

    initial begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic branch_t random_branch();
        branch_t bits;
        for (int b = 0; b < BRANCH_WIDTH; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[b]    = lfsr_state[0];
        end
        return bits;
    endfunction

    // lane number on top, sequence count below
    function automatic lane_entries_t build_entries(input logic [SEQ_WIDTH-1:0] seq,
                                                    input logic use_random);
        lane_entries_t entries;
        for (int i = 0; i < NUM_LANES; i++) begin
            entries[i].data   = {lane_t'(i), seq};
            entries[i].branch = use_random ? random_branch() : branch_t'(i);
        end
        return entries;
    endfunction

    function automatic logic model_empty();
        for (int i = 0; i < NUM_LANES; i++) begin
            if (model_q[i].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_valid(input string name, input lane_mask_t got,
                               input lane_mask_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("error: %s got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    // the output word of each rising edge is predicted before the offered beat is taken
    task automatic advance_model(output logic accepted);
        logic        room;
        logic        found;
        lane_t       lane;
        lane_entry_t head;
        @(posedge i_clock);
        room = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (model_q[i].size() >= LANE_DEPTH) begin
                room = 1'b0;
            end
        end
        found     = 1'b0;
        exp_valid = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane = model_ptr + lane_t'(i);
            if (!found && model_q[lane].size() != 0) begin
                found                  = 1'b1;
                head                   = model_q[lane].pop_front();
                exp_valid[head.branch] = 1'b1;
                exp_data               = head.data;
            end
        end
        accepted = i_valid && room;
        if (accepted) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                model_q[i].push_back(i_entries[i]);
            end
        end
        exp_ready = 1'b1;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (model_q[i].size() >= LANE_DEPTH) begin
                exp_ready = 1'b0;
            end
        end
        model_ptr = model_ptr + lane_t'(1);
    endtask

    task automatic compare_outputs();
        lane_t src_lane;
        @(negedge i_clock);
        check_valid("o_valid", o_valid, exp_valid);
        check_ready("o_ready", o_ready, exp_ready);
        if (o_valid != '0) begin
            delivered++;
        end
        if (exp_valid != '0) begin
            check_data("o_data", o_data, exp_data);
            // words of one lane must come out in acceptance order
            src_lane = o_data[DATA_WIDTH-1 -: BRANCH_WIDTH];
            check_data("o_data lane order", o_data, {src_lane, next_seq[src_lane]});
            next_seq[src_lane] = next_seq[src_lane] + SEQ_WIDTH'(1);
        end
    endtask

    initial begin
        int                   limit;
        limit = 0;
        for (int s = 0; s < STEP_COUNT; s++) begin
            limit += STEP_TABLE[s].beats * (1 + STEP_TABLE[s].gap);
        end
        limit = limit * 8 + 200;
        repeat (limit) @(posedge i_clock);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int                   beats_done;
        int                   gap_left;
        int                   stall_cycles;
        int                   errors_at_start;
        logic                 offering;
        logic                 accepted;
        logic                 busy;
        logic [SEQ_WIDTH-1:0] seq;
        i_reset     = 1'b1;
        i_valid     = 1'b0;
        i_entries   = '0;
        lfsr_state  = 16'd11663;
        model_ptr   = '0;
        exp_valid   = '0;
        exp_data    = '0;
        exp_ready   = 1'b1;
        seq         = '0;
        error_count = 0;
        check_count = 0;
        delivered   = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            next_seq[i] = '0;
        end
        repeat (16) @(posedge i_clock);
        i_reset <= 1'b0;

        // nothing may be written while idle after reset
        for (int c = 0; c < 4; c++) begin
            advance_model(accepted);
            compare_outputs();
        end
        $display("test reset: deliveries %0d, errors %0d", delivered, error_count);

        for (int s = 0; s < STEP_COUNT; s++) begin
            beats_done      = 0;
            gap_left        = 0;
            stall_cycles    = 0;
            offering        = 1'b0;
            delivered       = 0;
            errors_at_start = error_count;
            busy            = 1'b1;
            while (busy) begin
                advance_model(accepted);
                if (accepted) begin
                    beats_done++;
                    seq      = seq + SEQ_WIDTH'(1);
                    offering = 1'b0;
                    gap_left = STEP_TABLE[s].gap;
                end else if (offering) begin
                    stall_cycles++;
                end
                // a refused beat stays on the inputs unchanged
                if (!offering && beats_done < STEP_TABLE[s].beats && gap_left == 0) begin
                    i_entries <= build_entries(seq, STEP_TABLE[s].rand_branch);
                    i_valid   <= 1'b1;
                    offering  = 1'b1;
                end else if (!offering) begin
                    i_valid <= 1'b0;
                    if (gap_left > 0) begin
                        gap_left--;
                    end
                end
                compare_outputs();
                busy = offering || beats_done < STEP_TABLE[s].beats || !model_empty();
            end
            if (delivered != NUM_LANES * beats_done) begin
                error_count++;
                $display("test %0d delivered %0d words for %0d accepted beats",
                         s, delivered, beats_done);
            end
            if (STEP_TABLE[s].expect_stall && stall_cycles == 0) begin
                error_count++;
                $display("test %0d never saw o_ready low under a full input stream", s);
            end
            $display("test %0d: beats %0d, deliveries %0d, stall cycles %0d, errors %0d",
                     s, beats_done, delivered, stall_cycles, error_count - errors_at_start);
        end

        $display("tests %0d, checks %0d, errors %0d", STEP_COUNT + 1, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : mimo_fifo_8_tb

`default_nettype wire

// ==== common/mimo_pkg.sv ====
// ====================
// shared lane count, word width and lane buffer depth
// pointer and count widths for the lane buffers
// packed entry types for one lane and for all lanes
// ====================

`default_nettype none

package mimo_pkg;

    localparam int NUM_LANES  = 8;
    localparam int DATA_WIDTH = 16;
    localparam int LANE_DEPTH = 16;

    // depth must stay a power of two, pointers wrap on their own
    localparam int LANE_PTR_WIDTH   = $clog2(LANE_DEPTH);
    localparam int LANE_COUNT_WIDTH = $clog2(LANE_DEPTH + 1);

    localparam int BRANCH_WIDTH = $clog2(NUM_LANES);

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [BRANCH_WIDTH-1:0] branch_t;
    typedef logic [BRANCH_WIDTH-1:0] lane_t;
    typedef logic [NUM_LANES-1:0]    lane_mask_t;

    // branch sits above the data word, 19 bits in all
    typedef struct packed {
        branch_t branch;
        data_t   data;
    } lane_entry_t;

    typedef lane_entry_t [NUM_LANES-1:0] lane_entries_t;

endpackage : mimo_pkg

`default_nettype wire

// ==== compile.f ====
+incdir+bench
common/mimo_pkg.sv
lane_buffer/lane_fifo.sv
lane_buffer/lane_buffer_bank.sv
design/rotating_arbiter.sv
design/write_dispatch.sv
design/mimo_fifo_8.sv
bench/mimo_fifo_8_tb.sv

// ==== design/mimo_fifo_8.sv ====
// ====================
// mimo_fifo_8 top level
// lane buffer bank, rotating arbiter, write dispatch
// ====================

`timescale 1ns/1ps
`default_nettype none

module mimo_fifo_8 import mimo_pkg::*; (
    input  wire logic          i_clock,
    input  wire logic          i_reset,
    input  wire lane_entries_t i_entries,
    input  wire logic          i_valid,
    output      logic          o_ready,
    output      data_t         o_data,
    output      lane_mask_t    o_valid
);

    lane_entries_t heads;
    lane_mask_t    head_valid;
    lane_mask_t    pop;
    lane_entry_t   grant_entry;
    logic          grant_valid;

    lane_buffer_bank lane_buffer_bank_i (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_entries    (i_entries),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_pop        (pop),
        .o_heads      (heads),
        .o_head_valid (head_valid)
    );

    rotating_arbiter rotating_arbiter_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_heads       (heads),
        .i_head_valid  (head_valid),
        .o_pop         (pop),
        .o_grant_entry (grant_entry),
        .o_grant_valid (grant_valid)
    );

    write_dispatch write_dispatch_i (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_grant_entry (grant_entry),
        .i_grant_valid (grant_valid),
        .o_data        (o_data),
        .o_valid       (o_valid)
    );

endmodule : mimo_fifo_8

`default_nettype wire

// ==== design/rotating_arbiter.sv ====
// ====================
// rotating_arbiter
// pointer that steps one lane per cycle
// first valid head at or after the pointer wins
// grant select and pop, all combinational
// ====================

`timescale 1ns/1ps
`default_nettype none

module rotating_arbiter import mimo_pkg::*; (
    input  wire logic          i_clock,
    input  wire logic          i_reset,
    input  wire lane_entries_t i_heads,
    input  wire lane_mask_t    i_head_valid,
    output      lane_mask_t    o_pop,
    output      lane_entry_t   o_grant_entry,
    output      logic          o_grant_valid
);

    lane_t pointer;
    lane_t grant_lane;
    logic  found;

    // steps every edge, granted or not, and wraps at eight
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pointer <= '0;
        end else begin
            pointer <= pointer + lane_t'(1);
        end
    end

    // search upward from the pointer, wrapping past lane 7
    always_comb begin
        lane_t candidate;

        found      = 1'b0;
        grant_lane = pointer;
        for (int i = 0; i < NUM_LANES; i++) begin
            candidate = pointer + lane_t'(i);
            if (!found && i_head_valid[candidate]) begin
                found      = 1'b1;
                grant_lane = candidate;
            end
        end
    end

    always_comb begin
        o_pop = '0;
        if (found) begin
            o_pop[grant_lane] = 1'b1;
        end
    end

    assign o_grant_entry = i_heads[grant_lane];
    assign o_grant_valid = found;

    // one lane drained per cycle, and never an empty one
    a_pop_onehot : assert property (
        @(posedge i_clock) disable iff (i_reset)
        $onehot0(o_pop)
    );

    a_pop_subset : assert property (
        @(posedge i_clock) disable iff (i_reset)
        (o_pop & ~i_head_valid) == '0
    );

endmodule : rotating_arbiter

`default_nettype wire

// ==== design/write_dispatch.sv ====
// ====================
// write_dispatch
// output register for the granted word
// branch decoded into a one-hot write strobe
// ====================

`timescale 1ns/1ps
`default_nettype none

module write_dispatch import mimo_pkg::*; (
    input  wire logic        i_clock,
    input  wire logic        i_reset,
    input  wire lane_entry_t i_grant_entry,
    input  wire logic        i_grant_valid,
    output      data_t       o_data,
    output      lane_mask_t  o_valid
);

    // data goes to every branch, the strobe picks the one that writes
    always_ff @(posedge i_clock) begin
        o_data <= i_grant_entry.data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= '0;
        end else begin
            o_valid <= '0;
            if (i_grant_valid) begin
                o_valid[i_grant_entry.branch] <= 1'b1;
            end
        end
    end

    a_strobe_onehot : assert property (
        @(posedge i_clock) disable iff (i_reset)
        $onehot0(o_valid)
    );

endmodule : write_dispatch

`default_nettype wire

// ==== lane_buffer/lane_buffer_bank.sv ====
// ====================
// lane_buffer_bank
// eight lane buffers written together
// combined ready from all not-full flags
// ====================

`timescale 1ns/1ps
`default_nettype none

module lane_buffer_bank import mimo_pkg::*; (
    input  wire logic          i_clock,
    input  wire logic          i_reset,
    input  wire lane_entries_t i_entries,
    input  wire logic          i_valid,
    output      logic          o_ready,
    input  wire lane_mask_t    i_pop,
    output      lane_entries_t o_heads,
    output      lane_mask_t    o_head_valid
);

    lane_mask_t full;
    logic       write_all;

    // ready only when every lane has room, so the lanes stay aligned
    assign o_ready   = ~|full;
    assign write_all = i_valid & o_ready;

    genvar g;
    generate
        for (g = 0; g < NUM_LANES; g++) begin : gen_lane
            lane_fifo lane_fifo_i (
                .i_clock      (i_clock),
                .i_reset      (i_reset),
                .i_write      (write_all),
                .i_entry      (i_entries[g]),
                .o_full       (full[g]),
                .i_read       (i_pop[g]),
                .o_head       (o_heads[g]),
                .o_head_valid (o_head_valid[g])
            );
        end
    endgenerate

endmodule : lane_buffer_bank

`default_nettype wire

// ==== lane_buffer/lane_fifo.sv ====
// ====================
// lane_fifo
// show-ahead circular buffer for one lane
// head is visible in the cycle after the write
// ====================

`timescale 1ns/1ps
`default_nettype none

module lane_fifo import mimo_pkg::*; (
    input  wire logic        i_clock,
    input  wire logic        i_reset,
    input  wire logic        i_write,
    input  wire lane_entry_t i_entry,
    output      logic        o_full,
    input  wire logic        i_read,
    output      lane_entry_t o_head,
    output      logic        o_head_valid
);

    lane_entry_t mem [LANE_DEPTH];

    logic [LANE_PTR_WIDTH-1:0]   wr_ptr;
    logic [LANE_PTR_WIDTH-1:0]   rd_ptr;
    logic [LANE_COUNT_WIDTH-1:0] count;

    // entry storage
    always_ff @(posedge i_clock) begin
        if (i_write) begin
            mem[wr_ptr] <= i_entry;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_write) begin
                wr_ptr <= wr_ptr + LANE_PTR_WIDTH'(1);
            end
            if (i_read) begin
                rd_ptr <= rd_ptr + LANE_PTR_WIDTH'(1);
            end
            // simultaneous read and write leaves the count alone
            if (i_write && !i_read) begin
                count <= count + LANE_COUNT_WIDTH'(1);
            end else if (i_read && !i_write) begin
                count <= count - LANE_COUNT_WIDTH'(1);
            end
        end
    end

    assign o_full       = (count == LANE_COUNT_WIDTH'(LANE_DEPTH));
    assign o_head_valid = (count != '0);
    assign o_head       = mem[rd_ptr];

    // the bank gates writes with the combined ready, the arbiter pops only valid heads
    a_no_overflow : assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(i_write && o_full)
    );

    a_no_underflow : assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(i_read && !o_head_valid)
    );

endmodule : lane_fifo

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mimo_fifo_8 testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mimo_fifo_8_tb -f compile.f \
    -o sim_mimo_fifo_8 > build.log 2>&1 &&
./obj_dir/sim_mimo_fifo_8 > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
